/* verilog.f */
hdl/ing_pkg.sv
hdl/ing_port_buffer.sv
hdl/ing_arbiter_fsm.sv
hdl/ing_frame_counters.sv
hdl/ing_output_stage.sv
hdl/ing_router_top.sv
sim/ing_router_tb.sv

/* Makefile */
# Verilator flow for the packet ingress aggregator

TB_TOP = ing_router_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall -f verilog.f --top-module ing_router_top

sim:
	verilator --binary -j 0 -f verilog.f --top-module $(TB_TOP) -o $(TB_TOP)
	./obj_dir/$(TB_TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim/ing_router_tb.sv */
// Testbench for the router packet ingress aggregator
// Table of packets checked against a per-port reference model
`default_nettype none

module ing_router_tb;

    import ing_pkg::*;

    typedef struct packed {
        logic [1:0] port;
        logic [4:0] len;
        logic [3:0] keep;
        logic [3:0] enable;
        logic       hold;
        logic [3:0] clear;
    } entry_t;

    logic      core_clk_ifc;
    logic      rst_n;
    ing_in_t   ports_in [NUM_PORTS-1:0];
    logic [NUM_PORTS-1:0] port_enable;
    logic [NUM_PORTS-1:0] cnts_clear;
    ing_out_t  bus_out;
    logic      bus_ready;
    ing_cnts_t cnts [NUM_PORTS-1:0];

    // Reference model state
    ing_word_t exp_q [NUM_PORTS][$];
    ing_cnts_t exp_cnts [NUM_PORTS];
    int        stored [NUM_PORTS];
    int        cur_port;
    int        last_port = NUM_PORTS - 1;
    bit        in_pkt;

    entry_t      tbl [$];
    logic [31:0] seed = 32'd68697;
    int          err_cnt;
    int          check_cnt;
    int          cycles;
    int          cycle_limit;

    ing_router_top UUT (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .ports_in     (ports_in),
        .port_enable  (port_enable),
        .cnts_clear   (cnts_clear),
        .bus_out      (bus_out),
        .bus_ready    (bus_ready),
        .cnts         (cnts)
    );

    always #10 core_clk_ifc = ~core_clk_ifc;

    //////////////////////////////
    // Helpers

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Next port with a stored packet, after the last one sent
    function automatic int next_rr_port(input int last);
        int cand;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            cand = (last + i) % NUM_PORTS;
            if (exp_q[cand].size() != 0) begin
                return cand;
            end
        end
        return -1;
    endfunction

    function automatic int pending_words();
        int n;
        n = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            n += exp_q[p].size();
        end
        return n;
    endfunction

    task automatic wait_cycle();
        @(posedge core_clk_ifc);
        #2;
    endtask

    task automatic check_word(input ing_out_t got, input ing_out_t exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("error at %0t: bus_out %h keep %b last %b port %0d, expected %h %b %b %0d",
                     $time, got.word.data, got.word.keep, got.word.last, got.port,
                     exp.word.data, exp.word.keep, exp.word.last, exp.port);
        end
    endtask

    task automatic check_cnts(input ing_cnts_t got, input ing_cnts_t exp, input int port);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("error at %0t: port %0d frames %0d drops %0d, expected frames %0d drops %0d",
                     $time, port, got.frames, got.drops, exp.frames, exp.drops);
        end
    endtask

    // Compare all counters mid cycle, then realign to the drive point
    task automatic check_all_cnts();
        @(negedge core_clk_ifc);
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_cnts(cnts[p], exp_cnts[p], p);
        end
        wait_cycle();
    endtask

    task automatic drain_all();
        bus_ready = 1'b1;
        while (pending_words() != 0) begin
            wait_cycle();
        end
    endtask

    task automatic pulse_clear(input logic [NUM_PORTS-1:0] mask);
        cnts_clear = mask;
        wait_cycle();
        cnts_clear = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (mask[p]) begin
                exp_cnts[p] = '0;
            end
        end
        check_all_cnts();
    endtask

    task automatic send_packet(input entry_t e);
        int        p;
        int        n;
        bit        accept;
        ing_word_t w;
        p = int'(e.port);
        n = int'(e.len);
        accept = 1'b0;
        // Admission rule on the first word
        if (e.enable[e.port]) begin
            if (BUF_DEPTH - stored[p] < MAX_PKT_WORDS) begin
                exp_cnts[p].drops = exp_cnts[p].drops + 1'b1;
            end else begin
                accept = 1'b1;
                stored[p] += n;
                exp_cnts[p].frames = exp_cnts[p].frames + 1'b1;
            end
        end
        for (int i = 0; i < n; i++) begin
            seed   = xorshift(seed);
            w.data = seed;
            w.keep = (i == n - 1) ? e.keep : 4'hF;
            w.last = (i == n - 1);
            if (accept) begin
                exp_q[p].push_back(w);
            end
            ports_in[p] = '{valid: 1'b1, word: w};
            wait_cycle();
        end
        ports_in[p].valid = 1'b0;
    endtask

    //////////////////////////////
    // Output monitor

    always @(negedge core_clk_ifc) begin
        ing_word_t exp_word;
        ing_out_t  exp_out;
        if (rst_n && bus_out.valid && bus_ready) begin
            if (!in_pkt) begin
                cur_port = next_rr_port(last_port);
            end
            if (cur_port < 0) begin
                err_cnt++;
                $display("error at %0t: unexpected word on bus_out from port %0d",
                         $time, bus_out.port);
            end else begin
                exp_word = exp_q[cur_port].pop_front();
                exp_out  = '{valid: 1'b1, word: exp_word, port: PORT_IDX_WIDTH'(cur_port)};
                check_word(bus_out, exp_out);
                stored[cur_port]--;
                in_pkt = !exp_word.last;
                if (exp_word.last) begin
                    last_port = cur_port;
                end
            end
        end
    end

    // Watchdog
    always @(posedge core_clk_ifc) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Run stopped after %0d cycles without finishing, %0d errors so far",
                     cycles, err_cnt);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // Main sequence

    initial begin
        int total;
        // port, len, last keep, enable, hold ready low, clear
        tbl.push_back('{2'd0, 5'd1,  4'b0001, 4'b1111, 1'b0, 4'b0000});
        tbl.push_back('{2'd1, 5'd5,  4'b0011, 4'b1111, 1'b0, 4'b0000});
        tbl.push_back('{2'd2, 5'd16, 4'b1111, 4'b1111, 1'b0, 4'b0000});
        tbl.push_back('{2'd3, 5'd8,  4'b0111, 4'b1111, 1'b0, 4'b0000});
        // Round-robin batch
        tbl.push_back('{2'd0, 5'd3,  4'b1111, 4'b1111, 1'b1, 4'b0000});
        tbl.push_back('{2'd1, 5'd2,  4'b0001, 4'b1111, 1'b1, 4'b0000});
        tbl.push_back('{2'd2, 5'd7,  4'b0011, 4'b1111, 1'b1, 4'b0000});
        tbl.push_back('{2'd3, 5'd4,  4'b0111, 4'b1111, 1'b1, 4'b0000});
        // Port 2 disabled
        tbl.push_back('{2'd2, 5'd6,  4'b1111, 4'b1011, 1'b0, 4'b0000});
        // Fill port 1 until the fifth packet is dropped
        for (int k = 0; k < 5; k++) begin
            tbl.push_back('{2'd1, 5'd16, 4'b1111, 4'b1111, 1'b1, 4'b0000});
        end
        // Queued behind stalled port 1 and served before its next packet
        tbl.push_back('{2'd2, 5'd4,  4'b0011, 4'b1111, 1'b1, 4'b0000});
        tbl.push_back('{2'd3, 5'd3,  4'b1111, 4'b1111, 1'b1, 4'b0000});
        tbl.push_back('{2'd3, 5'd9,  4'b0011, 4'b1111, 1'b0, 4'b0010});
        tbl.push_back('{2'd0, 5'd2,  4'b0111, 4'b1111, 1'b0, 4'b0000});

        total = 0;
        foreach (tbl[k]) begin
            total += int'(tbl[k].len);
        end
        cycle_limit = 4 * (total + 20 * tbl.size());

        core_clk_ifc = 1'b0;
        rst_n        = 1'b0;
        port_enable  = '0;
        cnts_clear   = '0;
        bus_ready    = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            ports_in[p]  = '0;
            exp_cnts[p]  = '0;
            stored[p]    = 0;
        end

        repeat (4) @(posedge core_clk_ifc);
        @(negedge core_clk_ifc);
        if (bus_out.valid !== 1'b0) begin
            err_cnt++;
            $display("error at %0t: bus_out valid is high during reset", $time);
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            check_cnts(cnts[p], exp_cnts[p], p);
        end
        wait_cycle();
        rst_n = 1'b1;
        wait_cycle();

        foreach (tbl[k]) begin
            if (tbl[k].hold) begin
                bus_ready = 1'b0;
            end else begin
                drain_all();
            end
            if (tbl[k].clear != '0) begin
                pulse_clear(tbl[k].clear);
            end
            port_enable = tbl[k].enable;
            send_packet(tbl[k]);
            if (!tbl[k].hold) begin
                drain_all();
            end
            repeat (4) wait_cycle();
            check_all_cnts();
        end

        drain_all();
        repeat (4) wait_cycle();
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (exp_q[p].size() != 0) begin
                err_cnt++;
                $display("Port %0d still has %0d expected words that never came out",
                         p, exp_q[p].size());
            end
        end

        $display("Summary: %0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/ing_router_top.sv */
// Router packet ingress aggregator top level
// Four port buffers merged onto one bus by a round-robin arbiter
`default_nettype none

module ing_router_top (
    input  var logic                           core_clk_ifc,
    input  var logic                           rst_n,
    input  var ing_pkg::ing_in_t               ports_in [ing_pkg::NUM_PORTS-1:0],
    input  var logic [ing_pkg::NUM_PORTS-1:0]  port_enable,
    input  var logic [ing_pkg::NUM_PORTS-1:0]  cnts_clear,
    output ing_pkg::ing_out_t                  bus_out,
    input  var logic                           bus_ready,
    output ing_pkg::ing_cnts_t                 cnts [ing_pkg::NUM_PORTS-1:0]
);

    import ing_pkg::*;

    ing_word_t                 heads [NUM_PORTS-1:0];
    logic [NUM_PORTS-1:0]      head_last;
    logic [NUM_PORTS-1:0]      pkt_avail;
    logic [NUM_PORTS-1:0]      frame_strobe;
    logic [NUM_PORTS-1:0]      drop_strobe;
    logic [NUM_PORTS-1:0]      rd_en;
    logic [PORT_IDX_WIDTH-1:0] grant;
    logic                      load;
    logic                      stage_ready;

    //////////////////////////////
    // Port buffers

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        ing_port_buffer u_buffer (
            .core_clk_ifc (core_clk_ifc),
            .rst_n        (rst_n),
            .port_in      (ports_in[i]),
            .enable       (port_enable[i]),
            .rd_en        (rd_en[i]),
            .head         (heads[i]),
            .pkt_avail    (pkt_avail[i]),
            .frame_strobe (frame_strobe[i]),
            .drop_strobe  (drop_strobe[i])
        );

        assign head_last[i] = heads[i].last;
    end

    //////////////////////////////
    // Arbitration and output

    ing_arbiter_fsm u_arbiter (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .pkt_avail    (pkt_avail),
        .head_last    (head_last),
        .stage_ready  (stage_ready),
        .grant        (grant),
        .rd_en        (rd_en),
        .load         (load)
    );

    ing_output_stage u_output (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .heads        (heads),
        .grant        (grant),
        .load         (load),
        .bus_ready    (bus_ready),
        .bus_out      (bus_out),
        .stage_ready  (stage_ready)
    );

    // Statistics
    ing_frame_counters u_counters (
        .core_clk_ifc (core_clk_ifc),
        .rst_n        (rst_n),
        .frame_strobe (frame_strobe),
        .drop_strobe  (drop_strobe),
        .cnts_clear   (cnts_clear),
        .cnts         (cnts)
    );

endmodule

`default_nettype wire

/* hdl/ing_output_stage.sv */
// Converged bus output register
// Captures the granted head word with its source port index
`default_nettype none

module ing_output_stage (
    input  var logic                                core_clk_ifc,
    input  var logic                                rst_n,
    input  var ing_pkg::ing_word_t                  heads [ing_pkg::NUM_PORTS-1:0],
    input  var logic [ing_pkg::PORT_IDX_WIDTH-1:0]  grant,
    input  var logic                                load,
    input  var logic                                bus_ready,
    output ing_pkg::ing_out_t                       bus_out,
    output logic                                    stage_ready
);

    import ing_pkg::*;

    logic                      out_valid;
    ing_word_t                 out_word;
    logic [PORT_IDX_WIDTH-1:0] out_port;

    // Empty now or draining on this edge
    assign stage_ready = !out_valid || bus_ready;

    assign bus_out = '{valid: out_valid, word: out_word, port: out_port};

    //////////////////////////////
    // Output register

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= 1'b1;
        end else if (bus_ready) begin
            out_valid <= 1'b0;
        end
    end

    // Payload only changes on a load, so it holds while stalled
    always_ff @(posedge core_clk_ifc) begin
        if (load) begin
            out_word <= heads[grant];
            out_port <= grant;
        end
    end

endmodule

`default_nettype wire

/* hdl/ing_frame_counters.sv */
// Per-port frame and drop counters with software clear
`default_nettype none

module ing_frame_counters (
    input  var logic                           core_clk_ifc,
    input  var logic                           rst_n,
    input  var logic [ing_pkg::NUM_PORTS-1:0]  frame_strobe,
    input  var logic [ing_pkg::NUM_PORTS-1:0]  drop_strobe,
    input  var logic [ing_pkg::NUM_PORTS-1:0]  cnts_clear,
    output ing_pkg::ing_cnts_t                 cnts [ing_pkg::NUM_PORTS-1:0]
);

    import ing_pkg::*;

    //////////////////////////////
    // Counters

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                cnts[p] <= '0;
            end
        end else begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                // Clear wins over a strobe in the same cycle
                if (cnts_clear[p]) begin
                    cnts[p] <= '0;
                end else begin
                    if (frame_strobe[p]) begin
                        cnts[p].frames <= cnts[p].frames + 1'b1;
                    end
                    if (drop_strobe[p]) begin
                        cnts[p].drops <= cnts[p].drops + 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/ing_arbiter_fsm.sv */
// Round-robin packet arbiter
// Grants one buffer with a complete packet and reads it out whole
`default_nettype none

module ing_arbiter_fsm (
    input  var logic                                core_clk_ifc,
    input  var logic                                rst_n,
    input  var logic [ing_pkg::NUM_PORTS-1:0]       pkt_avail,
    input  var logic [ing_pkg::NUM_PORTS-1:0]       head_last,
    input  var logic                                stage_ready,
    output logic [ing_pkg::PORT_IDX_WIDTH-1:0]      grant,
    output logic [ing_pkg::NUM_PORTS-1:0]           rd_en,
    output logic                                    load
);

    import ing_pkg::*;

    arb_state_t                state;
    logic                      found;
    logic [PORT_IDX_WIDTH-1:0] next_port;

    //////////////////////////////
    // Round-robin search

    // Starts at the port after the last grant
    always_comb begin : rr_search
        logic [PORT_IDX_WIDTH-1:0] cand;
        found     = 1'b0;
        next_port = grant;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            cand = grant + PORT_IDX_WIDTH'(i);
            if (!found && pkt_avail[cand]) begin
                found     = 1'b1;
                next_port = cand;
            end
        end
    end

    //////////////////////////////
    // Read pacing

    assign load  = (state == ARB_SEND) && stage_ready;
    assign rd_en = load ? (NUM_PORTS'(1) << grant) : '0;

    // Grant register doubles as the last granted port
    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            state <= ARB_IDLE;
            grant <= PORT_IDX_WIDTH'(NUM_PORTS - 1);
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (found) begin
                        grant <= next_port;
                        state <= ARB_SEND;
                    end
                end
                ARB_SEND: begin
                    // Hold the grant until the packet's last word is loaded
                    if (load && head_last[grant]) begin
                        state <= ARB_IDLE;
                    end
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/ing_port_buffer.sv */
// Ingress port store-and-forward buffer
// Admits or drops whole packets and tracks complete packets held
`default_nettype none

module ing_port_buffer (
    input  var logic               core_clk_ifc,
    input  var logic               rst_n,
    input  var ing_pkg::ing_in_t   port_in,
    input  var logic               enable,
    input  var logic               rd_en,
    output ing_pkg::ing_word_t     head,
    output logic                   pkt_avail,
    output logic                   frame_strobe,
    output logic                   drop_strobe
);

    import ing_pkg::*;

    //////////////////////////////
    // Storage and pointers

    ing_word_t                 mem [BUF_DEPTH];
    logic [BUF_ADDR_WIDTH-1:0] wr_ptr;
    logic [BUF_ADDR_WIDTH-1:0] rd_ptr;
    logic [BUF_ADDR_WIDTH:0]   word_cnt;
    logic [BUF_ADDR_WIDTH:0]   pkt_cnt;
    logic [BUF_ADDR_WIDTH:0]   free_words;

    // Write side packet state
    logic in_pkt;
    logic keep_pkt;

    logic first_word;
    logic room;
    logic wr;
    logic pkt_in;
    logic pkt_out;

    assign free_words = (BUF_ADDR_WIDTH+1)'(BUF_DEPTH) - word_cnt;

    // Space for a full size packet is needed up front
    assign room       = free_words >= (BUF_ADDR_WIDTH+1)'(MAX_PKT_WORDS);
    assign first_word = port_in.valid && !in_pkt;
    assign wr         = port_in.valid && (in_pkt ? keep_pkt : (enable && room));
    assign pkt_in     = wr && port_in.word.last;
    assign pkt_out    = rd_en && head.last;

    assign head      = mem[rd_ptr];
    assign pkt_avail = pkt_cnt != '0;

    always_ff @(posedge core_clk_ifc) begin
        if (wr) begin
            mem[wr_ptr] <= port_in.word;
        end
    end

    //////////////////////////////
    // Admission decision

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            in_pkt       <= 1'b0;
            keep_pkt     <= 1'b0;
            frame_strobe <= 1'b0;
            drop_strobe  <= 1'b0;
        end else begin
            if (port_in.valid) begin
                in_pkt <= !port_in.word.last;
                if (first_word) begin
                    keep_pkt <= enable && room;
                end
            end
            frame_strobe <= pkt_in;
            // Disabled ports discard silently
            drop_strobe  <= first_word && enable && !room;
        end
    end

    //////////////////////////////
    // Pointers and occupancy

    always_ff @(posedge core_clk_ifc or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            word_cnt <= '0;
            pkt_cnt  <= '0;
        end else begin
            if (wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr, rd_en})
                2'b10:   word_cnt <= word_cnt + 1'b1;
                2'b01:   word_cnt <= word_cnt - 1'b1;
                default: word_cnt <= word_cnt;
            endcase
            // Complete packets held
            case ({pkt_in, pkt_out})
                2'b10:   pkt_cnt <= pkt_cnt + 1'b1;
                2'b01:   pkt_cnt <= pkt_cnt - 1'b1;
                default: pkt_cnt <= pkt_cnt;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/ing_pkg.sv */
// Packet ingress aggregator shared definitions
// Sizes, bus word structs, counter struct and arbiter state
`default_nettype none

package ing_pkg;

    //////////////////////////////
    // Sizes

    localparam int NUM_PORTS      = 4;
    localparam int PORT_IDX_WIDTH = 2;
    localparam int DATA_BYTES     = 4;
    localparam int BUF_DEPTH      = 64;
    localparam int BUF_ADDR_WIDTH = 6;
    localparam int MAX_PKT_WORDS  = 16;
    localparam int CNT_WIDTH      = 16;

    //////////////////////////////
    // Bus types

    // One stream word with keep all ones except possibly on the last word
    typedef struct packed {
        logic [DATA_BYTES*8-1:0] data;
        logic [DATA_BYTES-1:0]   keep;
        logic                    last;
    } ing_word_t;

    // Ingress port strobe bundle
    typedef struct packed {
        logic      valid;
        ing_word_t word;
    } ing_in_t;

    // Converged output bus without ready
    typedef struct packed {
        logic                      valid;
        ing_word_t                 word;
        logic [PORT_IDX_WIDTH-1:0] port;
    } ing_out_t;

    typedef struct packed {
        logic [CNT_WIDTH-1:0] frames;
        logic [CNT_WIDTH-1:0] drops;
    } ing_cnts_t;

    typedef enum logic {
        ARB_IDLE,
        ARB_SEND
    } arb_state_t;

endpackage

`default_nettype wire
